// File: Bender.yml
package:
  name: usb_tx

sources:
  - include_dirs:
      - include
    files:
      - rtl/usb_tx_pkg.sv
      - rtl/usb_tx_config.sv
      - rtl/usb_tx_timing.sv
      - rtl/usb_tx_shifter.sv
      - rtl/usb_tx_line.sv
      - rtl/usb_tx_sequencer.sv
      - rtl/usb_tx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/usb_line_monitor.sv
      - test/tb_usb_tx.sv

// File: include/usb_tx_defs.svh
`ifndef USB_TX_DEFS_SVH
`define USB_TX_DEFS_SVH

// clocks per bit time at full speed.
`define USB_FS_DIV 4

// clocks per bit time at low speed.
`define USB_LS_DIV 32

`endif

// File: list.f
+incdir+include
rtl/usb_tx_pkg.sv
rtl/usb_tx_config.sv
rtl/usb_tx_timing.sv
rtl/usb_tx_shifter.sv
rtl/usb_tx_line.sv
rtl/usb_tx_sequencer.sv
rtl/usb_tx_top.sv
test/usb_line_monitor.sv
test/tb_usb_tx.sv

// File: rtl/usb_tx_config.sv
`default_nettype none

module usb_tx_config (
	input  logic usb_clk,
	input  logic usb_rst,
	input  logic low_speed,
	input  logic generate_eop,
	input  logic line_idle,
	input  logic eop_clear,
	output logic ls_mode,
	output logic eop_pending
);

	// speed only follows low_speed between packets.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			ls_mode <= low_speed;
		end else if (line_idle) begin
			ls_mode <= low_speed;
		end
	end

	// sticky request, a new pulse in the same cycle as the clear wins.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			eop_pending <= 1'b0;
		end else if (generate_eop) begin
			eop_pending <= 1'b1;
		end else if (eop_clear) begin
			eop_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/usb_tx_line.sv
`default_nettype none

module usb_tx_line (
	input  logic                  usb_clk,
	input  logic                  usb_rst,
	input  logic                  bit_en,
	input  logic                  ls_mode,
	input  logic                  bit_out,
	input  usb_tx_pkg::line_ctl_t ctl,
	output usb_tx_pkg::usb_line_t line
);
	import usb_tx_pkg::*;

	usb_line_t pair_r;

	// nrzi stage, updated once per bit time.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			pair_r.p  <= ~ls_mode;
			pair_r.m  <= ls_mode;
			pair_r.oe <= 1'b0;
		end else if (bit_en) begin
			pair_r.oe <= ctl.oe;
			if (!ctl.oe) begin
				// undriven line rests at J for the speed in use.
				pair_r.p <= ~ls_mode;
				pair_r.m <= ls_mode;
			end else if (ctl.se0) begin
				pair_r.p <= 1'b0;
				pair_r.m <= 1'b0;
			end else if (ctl.j) begin
				pair_r.p <= ~ls_mode;
				pair_r.m <= ls_mode;
			end else if (!bit_out) begin
				pair_r.p <= ~pair_r.p;
				pair_r.m <= ~pair_r.m;
			end
		end
	end

	// output register.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			line.p  <= ~ls_mode;
			line.m  <= ls_mode;
			line.oe <= 1'b0;
		end else begin
			line <= pair_r;
		end
	end

endmodule

`default_nettype wire

// File: rtl/usb_tx_pkg.sv
`default_nettype none

package usb_tx_pkg;

	typedef logic [7:0] usb_byte_t;

	// per-bit-time command from the sequencer to the line block.
	typedef struct packed {
		logic oe;
		logic se0;
		logic j;
	} line_ctl_t;

	// differential pair state with its output enable.
	typedef struct packed {
		logic p;
		logic m;
		logic oe;
	} usb_line_t;

	typedef enum logic [2:0] {
		idle    = 3'd0,
		data    = 3'd1,
		eop1    = 3'd2,
		eop2    = 3'd3,
		j_state = 3'd4,
		geop1   = 3'd5,
		geop2   = 3'd6,
		gj      = 3'd7
	} tx_state_e;

endpackage

`default_nettype wire

// File: rtl/usb_tx_sequencer.sv
`default_nettype none

module usb_tx_sequencer (
	input  logic                  usb_clk,
	input  logic                  usb_rst,
	input  logic                  bit_en,
	input  logic                  tx_valid,
	input  logic                  sr_done,
	input  logic                  eop_pending,
	output logic                  sr_load,
	output logic                  sr_rst,
	output logic                  tx_ready,
	output logic                  eop_clear,
	output logic                  line_idle,
	output usb_tx_pkg::line_ctl_t ctl
);
	import usb_tx_pkg::*;

	tx_state_e state;
	tx_state_e next_state;
	logic      tx_valid_r;
	logic      tx_continue;
	logic      end_ack;

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state <= idle;
		end else if (bit_en) begin
			state <= next_state;
		end
	end

	// one clock wide, on the edge after the shifter took the byte.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			tx_ready <= 1'b0;
		end else begin
			tx_ready <= sr_load & bit_en;
		end
	end

	// falling tx_valid ends the packet after the byte in flight.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			tx_valid_r  <= 1'b0;
			tx_continue <= 1'b1;
		end else begin
			tx_valid_r <= tx_valid;
			if (tx_valid_r && !tx_valid) begin
				tx_continue <= 1'b0;
			end
			if (end_ack) begin
				tx_continue <= 1'b1;
			end
		end
	end

	assign line_idle = (state == idle);

	always_comb begin
		next_state = state;
		sr_load    = 1'b0;
		sr_rst     = 1'b0;
		eop_clear  = 1'b0;
		end_ack    = 1'b0;
		ctl        = '0;
		case (state)
			idle: begin
				if (eop_pending) begin
					sr_rst     = 1'b1;
					next_state = geop1;
				end else if (tx_valid) begin
					// keep the shifter cleared until the load edge.
					sr_load    = 1'b1;
					sr_rst     = ~bit_en;
					next_state = data;
				end else begin
					sr_rst = 1'b1;
				end
			end
			data: begin
				ctl.oe = 1'b1;
				if (sr_done) begin
					if (tx_continue) begin
						sr_load = 1'b1;
					end else begin
						next_state = eop1;
					end
				end
			end
			eop1: begin
				end_ack    = 1'b1;
				sr_rst     = 1'b1;
				ctl.oe     = 1'b1;
				ctl.se0    = 1'b1;
				next_state = eop2;
			end
			eop2: begin
				sr_rst     = 1'b1;
				ctl.oe     = 1'b1;
				ctl.se0    = 1'b1;
				next_state = j_state;
			end
			j_state: begin
				sr_rst     = 1'b1;
				ctl.oe     = 1'b1;
				ctl.j      = 1'b1;
				next_state = idle;
			end
			geop1: begin
				sr_rst     = 1'b1;
				ctl.oe     = 1'b1;
				ctl.se0    = 1'b1;
				next_state = geop2;
			end
			geop2: begin
				sr_rst     = 1'b1;
				ctl.oe     = 1'b1;
				ctl.se0    = 1'b1;
				next_state = gj;
			end
			gj: begin
				// request is dropped only once its burst has gone out.
				eop_clear  = bit_en;
				sr_rst     = 1'b1;
				ctl.oe     = 1'b1;
				ctl.j      = 1'b1;
				next_state = idle;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/usb_tx_shifter.sv
`default_nettype none

module usb_tx_shifter (
	input  logic                  usb_clk,
	input  logic                  bit_en,
	input  logic                  sr_load,
	input  logic                  sr_rst,
	input  usb_tx_pkg::usb_byte_t data,
	output logic                  bit_out,
	output logic                  sr_done
);

	logic [6:0] sr;
	logic [2:0] bitcount;
	logic [2:0] onecount;
	logic       stuff;

	// six ones in a row put a zero in place of the next bit.
	assign stuff = (onecount == 3'd6);

	always_ff @(posedge usb_clk) begin
		if (sr_rst) begin
			sr_done  <= 1'b1;
			onecount <= 3'd0;
			bit_out  <= 1'b1;
		end else if (bit_en) begin
			if (sr_load) begin
				// bit 0 goes out now, the rest wait in sr.
				sr_done  <= 1'b0;
				bit_out  <= data[0];
				bitcount <= 3'd0;
				sr       <= data[7:1];
				if (data[0]) begin
					onecount <= onecount + 3'd1;
				end else begin
					onecount <= 3'd0;
				end
			end else if (!sr_done) begin
				if (stuff) begin
					onecount <= 3'd0;
					bit_out  <= 1'b0;
					// stuffed zero after the last data bit.
					if (bitcount == 3'd7) begin
						sr_done <= 1'b1;
					end
				end else begin
					bit_out  <= sr[0];
					bitcount <= bitcount + 3'd1;
					sr       <= {1'b0, sr[6:1]};
					if (sr[0]) begin
						onecount <= onecount + 3'd1;
					end else begin
						onecount <= 3'd0;
					end
					// eighth bit out; hold done back if a stuffed zero must follow.
					if ((bitcount == 3'd6) && (!sr[0] || (onecount != 3'd5))) begin
						sr_done <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/usb_tx_timing.sv
`default_nettype none

module usb_tx_timing #(
	parameter int FS_DIV = 4,
	parameter int LS_DIV = 32
) (
	input  logic usb_clk,
	input  logic usb_rst,
	input  logic ls_mode,
	output logic bit_en
);

	localparam int MAX_DIV = (LS_DIV > FS_DIV) ? LS_DIV : FS_DIV;
	localparam int CW = $clog2(MAX_DIV);

	logic [CW-1:0] cnt;
	logic [CW-1:0] last;
	logic          wrap;

	assign last = ls_mode ? CW'(LS_DIV - 1) : CW'(FS_DIV - 1);
	// >= covers a count left above the limit by a speed change.
	assign wrap = (cnt >= last);

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			cnt    <= '0;
			bit_en <= 1'b0;
		end else begin
			cnt    <= wrap ? '0 : cnt + 1'b1;
			bit_en <= wrap;
		end
	end

endmodule

`default_nettype wire

// File: rtl/usb_tx_top.sv
`default_nettype none

`include "usb_tx_defs.svh"

module usb_tx_top #(
	parameter int FS_DIV = `USB_FS_DIV,
	parameter int LS_DIV = `USB_LS_DIV
) (
	input  logic                  usb_clk,
	input  logic                  usb_rst,
	input  usb_tx_pkg::usb_byte_t tx_data,
	input  logic                  tx_valid,
	input  logic                  low_speed,
	input  logic                  generate_eop,
	output logic                  tx_ready,
	output logic                  txp,
	output logic                  txm,
	output logic                  txoe
);
	import usb_tx_pkg::*;

	logic      ls_mode;
	logic      eop_pending;
	logic      eop_clear;
	logic      line_idle;
	logic      bit_en;
	logic      sr_load;
	logic      sr_rst;
	logic      sr_done;
	logic      bit_out;
	line_ctl_t ctl;
	usb_line_t line;

	usb_tx_config u_config (
		.usb_clk     (usb_clk),
		.usb_rst     (usb_rst),
		.low_speed   (low_speed),
		.generate_eop(generate_eop),
		.line_idle   (line_idle),
		.eop_clear   (eop_clear),
		.ls_mode     (ls_mode),
		.eop_pending (eop_pending)
	);

	usb_tx_timing #(
		.FS_DIV(FS_DIV),
		.LS_DIV(LS_DIV)
	) u_timing (
		.usb_clk(usb_clk),
		.usb_rst(usb_rst),
		.ls_mode(ls_mode),
		.bit_en (bit_en)
	);

	usb_tx_shifter u_shifter (
		.usb_clk(usb_clk),
		.bit_en (bit_en),
		.sr_load(sr_load),
		.sr_rst (sr_rst),
		.data   (tx_data),
		.bit_out(bit_out),
		.sr_done(sr_done)
	);

	usb_tx_line u_line (
		.usb_clk(usb_clk),
		.usb_rst(usb_rst),
		.bit_en (bit_en),
		.ls_mode(ls_mode),
		.bit_out(bit_out),
		.ctl    (ctl),
		.line   (line)
	);

	usb_tx_sequencer u_sequencer (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.bit_en     (bit_en),
		.tx_valid   (tx_valid),
		.sr_done    (sr_done),
		.eop_pending(eop_pending),
		.sr_load    (sr_load),
		.sr_rst     (sr_rst),
		.tx_ready   (tx_ready),
		.eop_clear  (eop_clear),
		.line_idle  (line_idle),
		.ctl        (ctl)
	);

	assign txp  = line.p;
	assign txm  = line.m;
	assign txoe = line.oe;

endmodule

`default_nettype wire

// File: test/tb_usb_tx.sv
`default_nettype none

`include "usb_tx_defs.svh"

module tb_usb_tx;
	import usb_tx_pkg::*;

	localparam int MAX_TESTS = 32;

	logic      usb_clk;
	logic      usb_rst;
	usb_byte_t tx_data;
	logic      tx_valid;
	logic      low_speed;
	logic      generate_eop;
	logic      tx_ready;
	logic      txp;
	logic      txm;
	logic      txoe;

	logic        mon_ls;
	logic        pkt_done;
	int          data_bits;
	logic [63:0] rx_data;
	int          stuff_count;
	int          se0_bits;
	int          j_bits;
	int          bad_bits;
	int          timing_errors;

	logic        is_eop [MAX_TESTS];
	logic        is_ls [MAX_TESTS];
	int          nbytes [MAX_TESTS];
	logic [63:0] pat_data [MAX_TESTS];
	int          num_tests;

	int cycle_count = 0;
	int cycle_limit = 0;
	int test_errs;
	int tests_ok;
	int tests_bad;

	usb_tx_top #(
		.FS_DIV(`USB_FS_DIV),
		.LS_DIV(`USB_LS_DIV)
	) dut (
		.usb_clk     (usb_clk),
		.usb_rst     (usb_rst),
		.tx_data     (tx_data),
		.tx_valid    (tx_valid),
		.low_speed   (low_speed),
		.generate_eop(generate_eop),
		.tx_ready    (tx_ready),
		.txp         (txp),
		.txm         (txm),
		.txoe        (txoe)
	);

	usb_line_monitor mon (
		.usb_clk      (usb_clk),
		.txp          (txp),
		.txm          (txm),
		.txoe         (txoe),
		.ls           (mon_ls),
		.pkt_done     (pkt_done),
		.data_bits    (data_bits),
		.rx_data      (rx_data),
		.stuff_count  (stuff_count),
		.se0_bits     (se0_bits),
		.j_bits       (j_bits),
		.bad_bits     (bad_bits),
		.timing_errors(timing_errors)
	);

	always #10 usb_clk = ~usb_clk;

	initial begin
		@(posedge usb_clk);
		cycle_count = cycle_count + 1;
		while (cycle_count <= cycle_limit) begin
			@(posedge usb_clk);
			cycle_count = cycle_count + 1;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Test failed");
		$finish;
	end

	task automatic report_mismatch(input string what, input int expected, input int got);
		$display("error %0t: %s expected %0d got %0d", $time, what, expected, got);
		test_errs++;
	endtask

	// one zero goes in after each run of six ones across byte boundaries.
	function automatic int expected_stuffing(input logic [63:0] bytes, input int n);
		int ones;
		int stuffs;
		int k;
		ones = 0;
		stuffs = 0;
		for (k = 0; k < n * 8; k++) begin
			if (bytes[k]) begin
				ones++;
			end else begin
				ones = 0;
			end
			if (ones == 6) begin
				stuffs++;
				ones = 0;
			end
		end
		return stuffs;
	endfunction

	task automatic load_patterns;
		int          fd;
		int          code;
		int          cnt;
		int          i;
		logic        stop;
		logic [7:0]  b;
		logic [63:0] kind;
		logic [63:0] speed;
		logic [1023:0] skip_buf;
		stop = 1'b0;
		fd = $fopen("test/usb_tx_patterns.txt", "r");
		if (fd == 0) begin
			$display("the pattern file test/usb_tx_patterns.txt could not be opened");
		end else begin
			while (!$feof(fd) && !stop && (num_tests < MAX_TESTS)) begin
				code = $fscanf(fd, "%s", kind);
				if (code != 1) begin
					stop = 1'b1;
				end else if (kind == "#") begin
					code = $fgets(skip_buf, fd);
				end else begin
					code = $fscanf(fd, "%s %d", speed, cnt);
					pat_data[num_tests] = '0;
					for (i = 0; i < cnt; i++) begin
						code = $fscanf(fd, "%h", b);
						pat_data[num_tests][i*8 +: 8] = b;
					end
					is_eop[num_tests] = (kind == "eop");
					is_ls[num_tests]  = (speed == "ls");
					nbytes[num_tests] = cnt;
					num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, test_errs);
		end
	endtask

	task automatic check_reset_state;
		test_errs = 0;
		repeat (3 * `USB_FS_DIV) begin
			if (txoe !== 1'b0) begin
				report_mismatch("txoe after reset", 0, txoe);
			end
			if ((txp !== 1'b1) || (txm !== 1'b0)) begin
				report_mismatch("pair after reset (p*2+m)", 2, {txp, txm});
			end
			if (tx_ready !== 1'b0) begin
				report_mismatch("tx_ready after reset", 0, tx_ready);
			end
			@(posedge usb_clk);
			#2;
		end
		finish_test("test 0 reset state");
	endtask

	task automatic settle_speed(input logic ls);
		if (low_speed != ls) begin
			low_speed = ls;
			repeat (2 * `USB_LS_DIV) @(posedge usb_clk);
		end else begin
			repeat (2 * `USB_FS_DIV) @(posedge usb_clk);
		end
		#2;
	endtask

	task automatic run_test(input int t);
		int idx;
		int readies;
		int n;
		int i;
		int timing_before;
		n = nbytes[t];
		idx = 0;
		readies = 0;
		test_errs = 0;
		settle_speed(is_ls[t]);
		mon_ls = is_ls[t];
		timing_before = timing_errors;
		// idle pair must sit at J for the speed.
		if ((txoe !== 1'b0) || (txp !== ~is_ls[t]) || (txm !== is_ls[t])) begin
			report_mismatch("idle line (oe*4+p*2+m)", {1'b0, ~is_ls[t], is_ls[t]},
				{txoe, txp, txm});
		end
		if (is_eop[t]) begin
			generate_eop = 1'b1;
		end else begin
			tx_data  = pat_data[t][7:0];
			tx_valid = 1'b1;
		end
		@(posedge usb_clk);
		#2;
		generate_eop = 1'b0;
		while (!pkt_done) begin
			if (tx_ready) begin
				readies++;
				idx++;
				// a speed change in mid packet must not reach the line.
				if (is_ls[t] && (idx == 1) && (n > 1)) begin
					low_speed = 1'b0;
				end
				if (idx < n) begin
					tx_data = pat_data[t][idx*8 +: 8];
				end else begin
					tx_valid  = 1'b0;
					low_speed = is_ls[t];
				end
			end
			@(posedge usb_clk);
			#2;
		end
		if (readies != n) begin
			report_mismatch("tx_ready pulses", n, readies);
		end
		if (data_bits != n * 8) begin
			report_mismatch("decoded data bits", n * 8, data_bits);
		end
		for (i = 0; i < n; i++) begin
			if (rx_data[i*8 +: 8] !== pat_data[t][i*8 +: 8]) begin
				$display("error %0t: byte %0d expected %h got %h", $time, i,
					pat_data[t][i*8 +: 8], rx_data[i*8 +: 8]);
				test_errs++;
			end
		end
		if (stuff_count != expected_stuffing(pat_data[t], n)) begin
			report_mismatch("stuffed zeros", expected_stuffing(pat_data[t], n), stuff_count);
		end
		if (se0_bits != 2) begin
			report_mismatch("se0 bit times", 2, se0_bits);
		end
		if (j_bits != 1) begin
			report_mismatch("closing J bit times", 1, j_bits);
		end
		if (bad_bits != 0) begin
			report_mismatch("illegal line states", 0, bad_bits);
		end
		if (timing_errors != timing_before) begin
			report_mismatch("edges off the bit grid", 0, timing_errors - timing_before);
		end
		finish_test($sformatf("test %0d %0s %0s %0d bytes", t + 1,
			is_eop[t] ? "eop" : "packet", is_ls[t] ? "ls" : "fs", n));
	endtask

	initial begin
		int t;
		usb_clk      = 1'b0;
		usb_rst      = 1'b1;
		tx_data      = '0;
		tx_valid     = 1'b0;
		low_speed    = 1'b0;
		generate_eop = 1'b0;
		mon_ls       = 1'b0;
		tests_ok     = 0;
		tests_bad    = 0;
		num_tests    = 0;
		load_patterns();
		// twice the nominal length of every test plus the settling gaps.
		for (t = 0; t < num_tests; t++) begin
			cycle_limit += 2 * (nbytes[t] * 10 + 8) *
				(is_ls[t] ? `USB_LS_DIV : `USB_FS_DIV);
			cycle_limit += 2 * `USB_LS_DIV + 16;
		end
		cycle_limit += 100;
		repeat (4) @(posedge usb_clk);
		#2;
		usb_rst = 1'b0;
		check_reset_state();
		for (t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		$display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
		if ((tests_bad == 0) && (num_tests > 0)) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/usb_line_monitor.sv
`default_nettype none

`include "usb_tx_defs.svh"

module usb_line_monitor (
	input  logic        usb_clk,
	input  logic        txp,
	input  logic        txm,
	input  logic        txoe,
	input  logic        ls,
	output logic        pkt_done,
	output int          data_bits,
	output logic [63:0] rx_data,
	output int          stuff_count,
	output int          se0_bits,
	output int          j_bits,
	output int          bad_bits,
	output int          timing_errors
);

	int   div;
	int   ones;
	int   edge_cyc = 0;
	int   edge_errs = 0;
	logic prev_p;
	logic in_eop;
	logic bit_val;
	logic oe_q = 1'b0;
	logic p_q = 1'b0;

	assign timing_errors = edge_errs;

	function automatic int bit_div(input logic low);
		return low ? `USB_LS_DIV : `USB_FS_DIV;
	endfunction

	// one line level per bit time, taken in the middle of the bit.
	task automatic decode_sample;
		if (!txp && !txm) begin
			// se0 after the closing J is out of order.
			if (j_bits != 0) begin
				bad_bits++;
			end
			se0_bits++;
			in_eop = 1'b1;
		end else if (txp == txm) begin
			bad_bits++;
		end else if (in_eop) begin
			if (txp == ~ls) begin
				j_bits++;
			end else begin
				bad_bits++;
			end
		end else begin
			// nrzi, an unchanged level is a one.
			bit_val = (txp == prev_p);
			prev_p = txp;
			if (ones == 6) begin
				if (bit_val) begin
					bad_bits++;
				end else begin
					stuff_count++;
				end
				ones = 0;
			end else begin
				if (data_bits < 64) begin
					rx_data[data_bits] = bit_val;
				end
				data_bits++;
				ones = bit_val ? ones + 1 : 0;
			end
		end
	endtask

	initial begin
		pkt_done    = 1'b0;
		data_bits   = 0;
		rx_data     = '0;
		stuff_count = 0;
		se0_bits    = 0;
		j_bits      = 0;
		bad_bits    = 0;
		forever begin
			@(posedge usb_clk);
			pkt_done = 1'b0;
			if (txoe === 1'b1) begin
				div         = bit_div(ls);
				prev_p      = ~ls;
				ones        = 0;
				in_eop      = 1'b0;
				data_bits   = 0;
				rx_data     = '0;
				stuff_count = 0;
				se0_bits    = 0;
				j_bits      = 0;
				bad_bits    = 0;
				repeat (div / 2 - 1) @(posedge usb_clk);
				while (txoe === 1'b1) begin
					decode_sample();
					repeat (div) @(posedge usb_clk);
				end
				pkt_done = 1'b1;
			end
		end
	end

	// pair edges while driven must fall on whole bit times from the txoe rise.
	always @(posedge usb_clk) begin
		if (txoe && !oe_q) begin
			edge_cyc = 0;
		end else begin
			edge_cyc = edge_cyc + 1;
		end
		if (txoe && (txp != p_q) && ((edge_cyc % bit_div(ls)) != 0)) begin
			edge_errs++;
		end
		oe_q = txoe;
		p_q  = txp;
	end

endmodule

`default_nettype wire

// File: test/usb_tx_patterns.txt
# kind speed count byte...
# kind is packet or eop, speed is fs or ls, bytes in hex and sent lsb first
packet fs 1 a5
packet fs 4 80 c3 5a 01
packet fs 3 ff ff ff
packet fs 2 fc 80
packet fs 3 f8 ff 01
packet fs 8 00 01 02 03 04 05 06 07
eop fs 0
packet fs 2 3f 7e
packet ls 3 80 2d ff
packet ls 1 7f
eop ls 0
packet ls 2 a5 ff
packet fs 2 fe 03
packet fs 5 80 ff 00 fc 1f
packet fs 1 ff
eop fs 0
